//--- cache_controller.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_controller (
	input  logic                    clk,
	input  logic                    arst_n,
	input  cache_pkg::cache_req_t   req,
	input  cache_pkg::tag_entry_t   rentry,
	input  logic                    busy,
	input  logic                    fill_rd,
	input  cache_pkg::cache_addr_u  fill_addr,
	input  logic [`OFFSET_BITS-1:0] fill_offset,
	input  logic                    fill_data_write,
	input  logic [15:0]             mem_rdata,
	output logic [`INDEX_BITS-1:0]  index,
	output logic [`OFFSET_BITS-1:0] offset,
	output logic                    data_write,
	output logic [15:0]             data_wdata,
	output logic                    miss,
	output cache_pkg::mem_req_t     mem_req,
	output logic                    stall
);

	// one extra stall cycle after miss or busy
	logic stall_q;
	// request taken this cycle
	logic accept;
	logic store;

	// invalid line or different tag
	assign miss = req.op && (!rentry.valid || (rentry.tag != req.addr.fields.tag));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stall_q <= 1'b0;
		end else begin
			stall_q <= miss || busy;
		end
	end

	// tag write settles during the extra cycle
	assign stall  = miss || busy || stall_q;
	assign accept = req.op && !stall;
	assign store  = accept && req.write;

	// processor holds its request, so index stays on the missing line
	assign index = req.addr.fields.index;

	// fill owns the word select and write data while busy
	assign offset     = busy ? fill_offset : req.addr.fields.offset;
	assign data_write = busy ? fill_data_write : store;
	assign data_wdata = busy ? mem_rdata : req.data;

	// fill reads while busy, write-through stores otherwise
	always_comb begin
		if (busy) begin
			mem_req.enable = fill_rd;
			mem_req.write  = 1'b0;
			mem_req.addr   = fill_addr.raw;
			mem_req.data   = '0;
		end else begin
			mem_req.enable = store;
			mem_req.write  = 1'b1;
			mem_req.addr   = req.addr.raw;
			mem_req.data   = req.data;
		end
	end

	// fill only starts from a miss, never on the edge of a store
	a_no_store_in_fill: assert property (
		@(posedge clk) disable iff (!arst_n)
		(mem_req.enable && mem_req.write) |=> !busy
	);

endmodule

//--- cache_data_array.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_data_array (
	input  logic                    clk,
	input  logic [`INDEX_BITS-1:0]  index,
	input  logic [`OFFSET_BITS-1:0] offset,
	input  logic                    write,
	input  logic [15:0]             wdata,
	output logic [15:0]             rdata
);

	// one flat word store, line-major
	localparam int DEPTH = `CACHE_LINES * `CACHE_WORDS;
	localparam int AW = `INDEX_BITS + `OFFSET_BITS;

	logic [15:0]   words [DEPTH];
	logic [AW-1:0] word_addr;

	// line picks the block, offset picks the word in it
	assign word_addr = {index, offset};

	// contents only mean something once the line is valid
	always_ff @(posedge clk) begin
		if (write) begin
			words[word_addr] <= wdata;
		end
	end

	// async read so a hit returns in the same cycle
	assign rdata = words[word_addr];

endmodule

//--- cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry
// 128 lines of 8 words, 16-bit words
`define CACHE_LINES 128
`define CACHE_WORDS 8

// address split, byte address of 16 bits
// tag + index + word offset + byte bit
`define TAG_BITS 5
`define INDEX_BITS 7
`define OFFSET_BITS 3

// backing memory
// cycles from read request to data_valid
`define MEM_LATENCY 4
// one word per even byte address
`define MEM_WORDS 32768

// start value of each memory word is its byte address xor this
`define MEM_INIT_XOR 16'h5a5a

`endif

//--- cache_fill_fsm.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_fill_fsm (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    miss,
	input  cache_pkg::cache_addr_u  miss_addr,
	input  logic                    data_valid,
	output logic                    busy,
	output logic                    mem_rd,
	output cache_pkg::cache_addr_u  mem_addr,
	output logic [`OFFSET_BITS-1:0] fill_offset,
	output logic                    data_write,
	output logic                    tag_write
);

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		DRAIN
	} fill_state_e;

	fill_state_e             state;
	// next word to request
	logic [`OFFSET_BITS-1:0] req_cnt;
	// next word to come back
	logic [`OFFSET_BITS-1:0] ret_cnt;
	cache_pkg::cache_addr_u  line_q;
	logic                    last_ret;

	// eighth return closes the fill
	assign last_ret = data_valid && (ret_cnt == `OFFSET_BITS'(`CACHE_WORDS - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= IDLE;
			req_cnt <= '0;
			ret_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (miss) begin
						state   <= REQUEST;
						req_cnt <= '0;
					end
				end
				// one read per cycle, words 0 to 7
				REQUEST: begin
					req_cnt <= req_cnt + 1'b1;
					if (req_cnt == `OFFSET_BITS'(`CACHE_WORDS - 1)) begin
						state <= DRAIN;
					end
				end
				// up to MEM_LATENCY reads still in flight
				DRAIN: begin
					if (last_ret) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
			// returns may start before all requests are out
			// counter wraps back to 0 after the last word
			if (data_valid) begin
				ret_cnt <= ret_cnt + 1'b1;
			end
		end
	end

	// missing line, held for the whole fill
	always_ff @(posedge clk) begin
		if (state == IDLE && miss) begin
			line_q <= miss_addr;
		end
	end

	// line-aligned word address
	always_comb begin
		mem_addr.fields.tag      = line_q.fields.tag;
		mem_addr.fields.index    = line_q.fields.index;
		mem_addr.fields.offset   = req_cnt;
		mem_addr.fields.byte_sel = 1'b0;
	end

	assign busy        = (state != IDLE);
	assign mem_rd      = (state == REQUEST);
	// returns come back in order
	assign fill_offset = ret_cnt;
	assign data_write  = data_valid && busy;
	// tag goes in with the last word, same edge
	assign tag_write   = last_ret && (state == DRAIN);

	// memory only returns data for reads issued here
	a_no_data_idle: assert property (
		@(posedge clk) disable iff (!arst_n)
		(state == IDLE) |-> !data_valid
	);

	// single tag write, a fixed time after the fill starts
	a_tag_write_pulse: assert property (
		@(posedge clk) disable iff (!arst_n)
		tag_write |-> $past(busy, `CACHE_WORDS + `MEM_LATENCY - 1)
			&& !$past(busy, `CACHE_WORDS + `MEM_LATENCY)
	);

endmodule

//--- cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

	// byte address seen as cache fields, msb first
	typedef struct packed {
		logic [`TAG_BITS-1:0]    tag;
		logic [`INDEX_BITS-1:0]  index;
		logic [`OFFSET_BITS-1:0] offset;
		// byte within word, ignored by the cache
		logic                    byte_sel;
	} cache_addr_fields_t;

	// one address, two views
	typedef union packed {
		logic [15:0]        raw;
		cache_addr_fields_t fields;
	} cache_addr_u;

	// processor request as held on the pins
	typedef struct packed {
		logic        op;
		logic        write;
		cache_addr_u addr;
		logic [15:0] data;
	} cache_req_t;

	// one tag array entry
	typedef struct packed {
		logic                 valid;
		logic [`TAG_BITS-1:0] tag;
	} tag_entry_t;

	// request into the backing memory
	typedef struct packed {
		logic        enable;
		logic        write;
		logic [15:0] addr;
		logic [15:0] data;
	} mem_req_t;

endpackage

//--- cache_tag_array.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tag_array (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [`INDEX_BITS-1:0] index,
	input  logic                   write,
	input  cache_pkg::tag_entry_t  wentry,
	output cache_pkg::tag_entry_t  rentry
);

	// valid bits need reset, tags do not
	logic [`CACHE_LINES-1:0] valid_q;
	logic [`TAG_BITS-1:0]    tags [`CACHE_LINES];

	// whole cache invalid after reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (write) begin
			valid_q[index] <= wentry.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (write) begin
			tags[index] <= wentry.tag;
		end
	end

	// async lookup for same-cycle hit detect
	assign rentry.valid = valid_q[index];
	assign rentry.tag   = tags[index];

	// fill only ever installs live lines
	a_write_valid: assert property (
		@(posedge clk) disable iff (!arst_n)
		write |-> wentry.valid
	);

endmodule

//--- cache_top.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_top (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        op,
	input  logic        write,
	input  logic [15:0] address_in,
	input  logic [15:0] data_in,
	output logic [15:0] data_out,
	output logic        stall
);

	cache_pkg::cache_req_t   req;
	cache_pkg::tag_entry_t   rentry;
	cache_pkg::tag_entry_t   tag_wentry;
	cache_pkg::cache_addr_u  fill_addr;
	cache_pkg::mem_req_t     mem_req;
	logic [`INDEX_BITS-1:0]  index;
	logic [`OFFSET_BITS-1:0] offset;
	logic [`OFFSET_BITS-1:0] fill_offset;
	logic [15:0]             data_wdata;
	logic [15:0]             mem_rdata;
	logic                    data_write;
	logic                    fill_data_write;
	logic                    tag_write;
	logic                    miss;
	logic                    busy;
	logic                    fill_rd;
	logic                    data_valid;

	// pins into one request
	assign req.op       = op;
	assign req.write    = write;
	assign req.addr.raw = address_in;
	assign req.data     = data_in;

	// new entry takes the tag of the line being filled
	assign tag_wentry.valid = 1'b1;
	assign tag_wentry.tag   = fill_addr.fields.tag;

	cache_controller cache_controller_i (
		.clk(clk), .arst_n(arst_n), .req(req), .rentry(rentry),
		.busy(busy), .fill_rd(fill_rd), .fill_addr(fill_addr),
		.fill_offset(fill_offset), .fill_data_write(fill_data_write),
		.mem_rdata(mem_rdata), .index(index), .offset(offset),
		.data_write(data_write), .data_wdata(data_wdata), .miss(miss),
		.mem_req(mem_req), .stall(stall)
	);

	cache_data_array cache_data_array_i (
		.clk(clk), .index(index), .offset(offset), .write(data_write),
		.wdata(data_wdata), .rdata(data_out)
	);

	cache_tag_array cache_tag_array_i (
		.clk(clk), .arst_n(arst_n), .index(index), .write(tag_write),
		.wentry(tag_wentry), .rentry(rentry)
	);

	// missing line comes straight from the held request
	cache_fill_fsm cache_fill_fsm_i (
		.clk(clk), .arst_n(arst_n), .miss(miss), .miss_addr(req.addr),
		.data_valid(data_valid), .busy(busy), .mem_rd(fill_rd),
		.mem_addr(fill_addr), .fill_offset(fill_offset),
		.data_write(fill_data_write), .tag_write(tag_write)
	);

	main_memory main_memory_i (
		.clk(clk), .arst_n(arst_n), .req(mem_req), .rdata(mem_rdata),
		.data_valid(data_valid)
	);

endmodule

//--- main_memory.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module main_memory (
	input  logic                 clk,
	input  logic                 arst_n,
	input  cache_pkg::mem_req_t  req,
	output logic [15:0]          rdata,
	output logic                 data_valid
);

	localparam int AW = $clog2(`MEM_WORDS);

	logic [15:0]             storage [`MEM_WORDS];
	// read pipeline, valid and word address per stage
	logic [`MEM_LATENCY-1:0] pipe_valid;
	logic [AW-1:0]           pipe_addr [`MEM_LATENCY];
	logic [AW-1:0]           word_addr;
	logic                    rd_req;
	logic                    wr_req;

	// byte address to word address
	assign word_addr = req.addr[AW:1];
	assign rd_req    = req.enable && !req.write;
	assign wr_req    = req.enable && req.write;

	// word i holds its byte address xor the pattern
	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			storage[i] = 16'(i << 1) ^ `MEM_INIT_XOR;
		end
	end

	// stores land at the edge, nothing comes back
	always_ff @(posedge clk) begin
		if (wr_req) begin
			storage[word_addr] <= req.data;
		end
	end

	// several reads can be in flight at once
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[`MEM_LATENCY-2:0], rd_req};
		end
	end

	always_ff @(posedge clk) begin
		pipe_addr[0] <= word_addr;
		for (int s = 1; s < `MEM_LATENCY; s++) begin
			pipe_addr[s] <= pipe_addr[s-1];
		end
	end

	// data read at the end of the pipe
	assign data_valid = pipe_valid[`MEM_LATENCY-1];
	assign rdata      = storage[pipe_addr[`MEM_LATENCY-1]];

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cache -f vlog.f

# the simulator exit status is not the verdict, the pass line is
sim_out="$(./obj_dir/Vtb_cache || true)"
echo "$sim_out"

if grep -qx "All tests passed" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi

//--- tb_cache.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module tb_cache;

	localparam int N_DIRECTED   = 18;
	localparam int N_RANDOM     = 400;
	localparam int RESET_CYCLES = 10;
	// miss cycle, eight reads, memory latency, tag write, extra stall
	localparam int FILL_STALL     = `CACHE_WORDS + `MEM_LATENCY + 2;
	localparam int TIMEOUT_CYCLES = 40 * (N_DIRECTED + N_RANDOM) + RESET_CYCLES;

	logic        clk;
	logic        arst_n;
	logic        op;
	logic        write;
	logic [15:0] address_in;
	logic [15:0] data_in;
	logic [15:0] data_out;
	logic        stall;

	// reference memory and tag model
	logic [15:0]          ref_mem [`MEM_WORDS];
	logic [`CACHE_LINES-1:0] tag_valid;
	logic [`TAG_BITS-1:0] tag_model [`CACHE_LINES];

	// reads waiting for the compare process
	string       cmp_name_q [$];
	logic [15:0] cmp_exp_q [$];
	logic [15:0] cmp_act_q [$];

	int cycle_cnt;

	cache_top cache_top_i (
		.clk(clk), .arst_n(arst_n), .op(op), .write(write),
		.address_in(address_in), .data_in(data_in),
		.data_out(data_out), .stall(stall)
	);

	// 10 ns period
	always #5 clk = ~clk;

	// expected read word from the reference memory
	function automatic logic [15:0] expected_read(input logic [15:0] addr);
		return ref_mem[addr[15:1]];
	endfunction

	// hit or miss from the tag model
	function automatic logic predict_miss(input cache_pkg::cache_addr_u a);
		return !(tag_valid[a.fields.index] && (tag_model[a.fields.index] == a.fields.tag));
	endfunction

	task automatic check(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// one processor access, held until stall drops
	task automatic access(input string name, input logic wr, input logic [15:0] addr,
			input logic [15:0] data);
		cache_pkg::cache_addr_u a;
		logic                   exp_miss;
		int                     stall_cycles;
		a.raw    = addr;
		exp_miss = predict_miss(a);
		@(negedge clk);
		op         = 1'b1;
		write      = wr;
		address_in = addr;
		data_in    = data;
		#1;
		// hit must not stall in its first cycle
		check({name, " stall"}, 16'(exp_miss), 16'(stall));
		stall_cycles = 0;
		while (stall) begin
			stall_cycles++;
			@(negedge clk);
			#1;
		end
		if (exp_miss) begin
			check({name, " fill time"}, 16'(FILL_STALL), 16'(stall_cycles));
			tag_valid[a.fields.index] = 1'b1;
			tag_model[a.fields.index] = a.fields.tag;
		end
		// accepted at the next rising edge
		if (wr) begin
			ref_mem[addr[15:1]] = data;
		end else begin
			cmp_name_q.push_back(name);
			cmp_exp_q.push_back(expected_read(addr));
			cmp_act_q.push_back(data_out);
		end
	endtask

	// compare process, drains captured reads
	always @(posedge clk) begin
		while (cmp_exp_q.size() > 0) begin
			check(cmp_name_q.pop_front(), cmp_exp_q.pop_front(), cmp_act_q.pop_front());
		end
	end

	// run limit
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycle_cnt);
			$display("Some tests failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		logic [15:0] r_addr;
		logic [15:0] r_data;
		logic        r_write;
		clk        = 1'b0;
		arst_n     = 1'b0;
		op         = 1'b0;
		write      = 1'b0;
		address_in = '0;
		data_in    = '0;
		cycle_cnt  = 0;
		tag_valid  = '0;
		void'($urandom(32'h40f9));
		// same start pattern as the memory model
		for (int i = 0; i < `MEM_WORDS; i++) begin
			ref_mem[i] = 16'(i * 2) ^ `MEM_INIT_XOR;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		// read miss after reset
		access("read miss", 1'b0, 16'h0100, 16'h0000);
		// same line, now a hit
		access("read hit", 1'b0, 16'h0104, 16'h0000);

		// store hit, read back, evict and refill
		access("store hit", 1'b1, 16'h0106, 16'hbeef);
		access("read after store", 1'b0, 16'h0106, 16'h0000);
		access("evict line", 1'b0, 16'h0906, 16'h0000);
		access("refill after store", 1'b0, 16'h0106, 16'h0000);

		// store into a line not yet cached
		access("store miss", 1'b1, 16'h2230, 16'h1234);
		access("store miss neighbour", 1'b0, 16'h2232, 16'h0000);
		access("store miss word", 1'b0, 16'h2230, 16'h0000);
		access("store miss last word", 1'b0, 16'h223e, 16'h0000);

		// same index, tags differ in bit 11
		for (int k = 0; k < 4; k++) begin
			access($sformatf("conflict a %0d", k), 1'b0, 16'h4450, 16'h0000);
			access($sformatf("conflict b %0d", k), 1'b0, 16'h4c50, 16'h0000);
		end

		// small window, four indexes and four tags
		for (int n = 0; n < N_RANDOM; n++) begin
			r_addr  = 16'($urandom) & 16'h183e;
			r_write = (($urandom % 3) == 0);
			r_data  = 16'($urandom);
			access($sformatf("random %0d", n), r_write, r_addr, r_data);
		end

		@(negedge clk);
		op    = 1'b0;
		write = 1'b0;
		// let the compare process empty its queue
		@(posedge clk);
		@(negedge clk);
		if (cmp_exp_q.size() == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "checks did not complete");
		end
	end

endmodule

//--- vlog.f
+incdir+.
cache_pkg.sv
cache_data_array.sv
cache_tag_array.sv
cache_fill_fsm.sv
main_memory.sv
cache_controller.sv
cache_top.sv
tb_cache.sv
